/* hw/soc_pkg.sv */
package soc_pkg;

    // bus widths
    localparam int xlen = 64;                // data and address width
    localparam int ram_words = 1024;         // 32-bit words, 4 KiB
    localparam int ram_aw = $clog2(ram_words); // word index width
    localparam int sd_buf_aw = 9;            // byte index into sector buffer

    // address map
    localparam logic [xlen-1:0] ram_base = 64'h0000_0000_0000_0000;
    localparam logic [xlen-1:0] ram_size = 64'h0000_0000_0000_1000; // 4 KiB

    localparam logic [xlen-1:0] key_addr = 64'h0000_0000_1000_0000;  // ascii of last key
    localparam logic [xlen-1:0] uart_addr = 64'h0000_0000_1000_0008; // console data

    // sd card block
    localparam logic [xlen-1:0] sd_addr_reg = 64'h0000_0000_1000_0010;  // sector number
    localparam logic [xlen-1:0] sd_read_reg = 64'h0000_0000_1000_0018;  // write starts a read
    localparam logic [xlen-1:0] sd_ready_reg = 64'h0000_0000_1000_0020; // card idle
    localparam logic [xlen-1:0] sd_avail_reg = 64'h0000_0000_1000_0028; // sector in buffer
    localparam logic [xlen-1:0] sd_buf_base = 64'h0000_0000_1000_1000;  // 512-aligned window
    localparam logic [xlen-1:0] sd_buf_bytes = 64'd512;

    // load/store size, bit 2 = unsigned
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,  // also sd on the write side
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } access_t;

    // request from the bus master
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            rd;    // one-cycle strobe
        logic            wr;    // one-cycle strobe
        access_t         kind;
    } bus_req_t;

    // one-hot target select
    typedef struct packed {
        logic ram;
        logic key;
        logic uart;
        logic sd_addr;
        logic sd_read;
        logic sd_ready;
        logic sd_avail;
        logic sd_buf;
        logic none;  // nothing mapped here
    } target_sel_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
    } rsp_t;

endpackage

/* hw/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
    input  soc_pkg::bus_req_t    req,
    output soc_pkg::target_sel_t sel
);

    logic [soc_pkg::xlen-1:0] ram_off; // offset into ram region
    logic [soc_pkg::xlen-1:0] buf_off; // offset into sd window

    // subtract then compare, wraps below base to a huge value
    assign ram_off = req.addr - soc_pkg::ram_base;
    assign buf_off = req.addr - soc_pkg::sd_buf_base;

    always_comb begin
        sel = '0;
        if (ram_off < soc_pkg::ram_size) begin
            sel.ram = 1'b1;
        end else if (req.addr == soc_pkg::key_addr) begin
            sel.key = 1'b1;
        end else if (req.addr == soc_pkg::uart_addr) begin
            sel.uart = 1'b1;
        end else if (req.addr == soc_pkg::sd_addr_reg) begin
            sel.sd_addr = 1'b1;
        end else if (req.addr == soc_pkg::sd_read_reg) begin
            sel.sd_read = 1'b1;
        end else if (req.addr == soc_pkg::sd_ready_reg) begin
            sel.sd_ready = 1'b1;
        end else if (req.addr == soc_pkg::sd_avail_reg) begin
            sel.sd_avail = 1'b1;
        end else if (buf_off < soc_pkg::sd_buf_bytes) begin
            sel.sd_buf = 1'b1;
        end else begin
            sel.none = 1'b1; // unmapped, read_return answers zero
        end
    end

endmodule

/* hw/ram_port.sv */
`timescale 1ns/1ps

module ram_port (
    input  logic                 CLOCK_50,
    input  soc_pkg::bus_req_t    req,
    input  soc_pkg::target_sel_t sel,
    output soc_pkg::rsp_t        rsp
);

    logic [31:0] mem [0:soc_pkg::ram_words-1];

    logic [soc_pkg::ram_aw-1:0] idx;        // word addressed by request
    logic [1:0]                 off;        // byte within word
    logic                       is_dw;      // doubleword access

    logic [soc_pkg::ram_aw-1:0] wr_idx;
    logic [3:0]                 wr_be;
    logic [31:0]                wr_dat;
    logic                       wr_en;

    logic                       st_hi_pend; // upper word of sd still to write
    logic [soc_pkg::ram_aw-1:0] hi_idx_q;
    logic [31:0]                hi_word_q;

    logic                       ld_pend;    // second read of ld
    logic [soc_pkg::ram_aw-1:0] rd_idx;
    logic [31:0]                rd_q;       // sync read port
    logic [31:0]                lo_q;       // low half of ld
    logic                       valid_q;

    assign idx = req.addr[soc_pkg::ram_aw+1:2];
    assign off = req.addr[1:0];
    assign is_dw = (req.kind == soc_pkg::ld);

    // sign or zero extend the addressed field
    function automatic logic [63:0] load_ext(input logic [31:0] lo, input logic [31:0] hi,
                                             input soc_pkg::access_t kind,
                                             input logic [1:0] boff);
        logic [31:0] sh;
        sh = lo >> {boff, 3'b000};
        case (kind)
            soc_pkg::lb:  return {{56{sh[7]}}, sh[7:0]};
            soc_pkg::lh:  return {{48{sh[15]}}, sh[15:0]};
            soc_pkg::lw:  return {{32{sh[31]}}, sh};
            soc_pkg::ld:  return {hi, lo};
            soc_pkg::lbu: return {56'd0, sh[7:0]};
            soc_pkg::lhu: return {48'd0, sh[15:0]};
            soc_pkg::lwu: return {32'd0, sh};
            default:      return '0;
        endcase
    endfunction

    // byte lanes for the store
    always_comb begin
        wr_en = st_hi_pend | (req.wr & sel.ram);
        wr_idx = idx;
        wr_be = 4'b1111;
        wr_dat = req.wdata[31:0];
        if (st_hi_pend) begin
            wr_idx = hi_idx_q; // second half of sd
            wr_dat = hi_word_q;
        end else if (req.kind == soc_pkg::lb) begin
            wr_be = 4'b0001 << off;
            wr_dat = {4{req.wdata[7:0]}};  // replicate, lane picks
        end else if (req.kind == soc_pkg::lh) begin
            wr_be = 4'b0011 << {off[1], 1'b0};
            wr_dat = {2{req.wdata[15:0]}};
        end
    end

    assign rd_idx = ld_pend ? idx + 1'b1 : idx; // next word on ld

    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i]) mem[wr_idx][8*i +: 8] <= wr_dat[8*i +: 8];
            end
        end
        rd_q <= mem[rd_idx];
        if (ld_pend) lo_q <= rd_q; // keep low word while high is fetched
    end

    // sequencing, clears itself once strobes are idle
    always_ff @(posedge CLOCK_50) begin
        st_hi_pend <= req.wr & sel.ram & is_dw & ~st_hi_pend;
        hi_idx_q <= idx + 1'b1;
        hi_word_q <= req.wdata[63:32];
        ld_pend <= req.rd & sel.ram & is_dw;
        valid_q <= (req.rd & sel.ram & ~is_dw) | ld_pend;
    end

    assign rsp.valid = valid_q;
    assign rsp.data = load_ext(is_dw ? lo_q : rd_q, rd_q, req.kind, off);

endmodule

/* hw/periph_regs.sv */
`timescale 1ns/1ps

module periph_regs (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  soc_pkg::bus_req_t    req,
    input  soc_pkg::target_sel_t sel,
    output soc_pkg::rsp_t        rsp,
    input  logic                 key_pressed,
    input  logic [7:0]           key_ascii,
    input  logic                 irq_ack,
    output logic [3:0]           irq_vector,
    output logic [31:0]          sd_addr,
    output logic                 sd_rd_start,
    input  logic                 sd_byte_valid,
    input  logic [7:0]           sd_byte,
    input  logic                 sd_ready,
    output logic                 uart_wr,
    output logic [31:0]          uart_data
);

    logic [7:0] ascii_q;                     // last key seen
    logic [7:0] sbuf [0:soc_pkg::sd_buf_bytes-1];
    logic [soc_pkg::sd_buf_aw-1:0] sd_idx;   // fill pointer
    logic sd_valid_d;
    logic sd_avail;
    logic byte_rise;
    logic [7:0] byte_q;                      // buffer read port
    logic per_hit;
    logic [soc_pkg::xlen-1:0] rd_mux;
    logic [soc_pkg::xlen-1:0] data_q;
    logic buf_rd_q;                          // answer comes from byte_q
    logic valid_q;

    assign byte_rise = sd_byte_valid & ~sd_valid_d;
    assign per_hit = sel.key | sel.uart | sel.sd_addr | sel.sd_read | sel.sd_ready
                   | sel.sd_avail | sel.sd_buf;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ascii_q <= '0;
            irq_vector <= '0;
        end else begin
            if (key_pressed) ascii_q <= key_ascii;
            if (key_pressed && key_ascii != 8'd0) irq_vector <= 4'd1;
            if (irq_ack) irq_vector <= 4'd0; // ack wins
        end
    end

    // sd side, bytes land on rising edge of the valid level
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr <= '0;
            sd_rd_start <= 1'b0;
            sd_avail <= 1'b0;
            sd_idx <= '0;
            sd_valid_d <= 1'b0;
        end else begin
            sd_valid_d <= sd_byte_valid;
            sd_rd_start <= req.wr & sel.sd_read;
            if (req.wr && sel.sd_addr) sd_addr <= req.wdata[31:0];
            if (byte_rise) begin
                sd_idx <= sd_idx + 1'b1;       // wraps after 512
                if (sd_idx == '1) sd_avail <= 1'b1;
            end
            if (req.wr && sel.sd_read) begin
                sd_avail <= 1'b0;              // new sector on its way
                sd_idx <= '0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_rise) sbuf[sd_idx] <= sd_byte;
        byte_q <= sbuf[req.addr[soc_pkg::sd_buf_aw-1:0]];
    end

    // console strobe, wr is already a single-cycle pulse
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) uart_wr <= 1'b0;
        else uart_wr <= req.wr & sel.uart;
    end

    always_ff @(posedge CLOCK_50) begin
        if (req.wr && sel.uart) uart_data <= req.wdata[31:0];
    end

    always_comb begin
        rd_mux = '0;
        if (sel.key) rd_mux[7:0] = ascii_q;
        if (sel.sd_addr) rd_mux[31:0] = sd_addr; // readback
        if (sel.sd_ready) rd_mux[0] = sd_ready;
        if (sel.sd_avail) rd_mux[0] = sd_avail;
    end

    always_ff @(posedge CLOCK_50) begin
        data_q <= rd_mux;
        buf_rd_q <= sel.sd_buf;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) valid_q <= 1'b0;
        else valid_q <= req.rd & per_hit;
    end

    assign rsp.valid = valid_q;
    assign rsp.data = buf_rd_q ? {{(soc_pkg::xlen-8){1'b0}}, byte_q} : data_q;

endmodule

/* hw/read_return.sv */
`timescale 1ns/1ps

module read_return (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  soc_pkg::bus_req_t        req,
    input  soc_pkg::target_sel_t     sel,
    input  soc_pkg::rsp_t            ram_rsp,
    input  soc_pkg::rsp_t            per_rsp,
    output logic [soc_pkg::xlen-1:0] rdata,
    output logic                     done
);

    logic none_q; // unmapped read, answer next cycle

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            none_q <= 1'b0;
            done <= 1'b1; // idle bus reads as done
        end else begin
            none_q <= req.rd & sel.none;
            if (req.rd) done <= 1'b0;
            if (ram_rsp.valid || per_rsp.valid || none_q) done <= 1'b1;
        end
    end

    // capture whichever side answered
    always_ff @(posedge CLOCK_50) begin
        if (ram_rsp.valid) begin
            rdata <= ram_rsp.data;
        end else if (per_rsp.valid) begin
            rdata <= per_rsp.data;
        end else if (none_q) begin
            rdata <= '0;
        end
    end

endmodule

/* hw/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  soc_pkg::bus_req_t        bus_req,
    output logic [soc_pkg::xlen-1:0] bus_rdata,
    output logic                     bus_done,
    input  logic                     key_pressed,
    input  logic [7:0]               key_ascii,
    output logic [3:0]               irq_vector,
    input  logic                     irq_ack,
    output logic [31:0]              sd_addr,
    output logic                     sd_rd_start,
    input  logic                     sd_byte_valid,
    input  logic [7:0]               sd_byte,
    input  logic                     sd_ready,
    output logic                     uart_wr,
    output logic [31:0]              uart_data
);

    soc_pkg::target_sel_t sel;     // from decoder to all targets
    soc_pkg::rsp_t        ram_rsp;
    soc_pkg::rsp_t        per_rsp;

    bus_decode u_decode (.req(bus_req), .sel(sel));

    ram_port u_ram (.CLOCK_50(CLOCK_50), .req(bus_req), .sel(sel), .rsp(ram_rsp));

    periph_regs u_periph (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .req(bus_req), .sel(sel), .rsp(per_rsp),
        .key_pressed(key_pressed), .key_ascii(key_ascii),
        .irq_ack(irq_ack), .irq_vector(irq_vector),
        .sd_addr(sd_addr), .sd_rd_start(sd_rd_start),
        .sd_byte_valid(sd_byte_valid), .sd_byte(sd_byte), .sd_ready(sd_ready),
        .uart_wr(uart_wr), .uart_data(uart_data)
    );

    read_return u_ret (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .req(bus_req), .sel(sel),
        .ram_rsp(ram_rsp), .per_rsp(per_rsp),
        .rdata(bus_rdata), .done(bus_done)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50; // 10 ns period
    end

    // reset low for 8 cycles, let go on a falling edge
    initial begin
        KEY0 = 1'b0;
        repeat (8) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

/* testbench/tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;

    logic CLOCK_50;
    logic KEY0;
    soc_pkg::bus_req_t req;
    logic [63:0] bus_rdata;
    logic bus_done;
    logic key_pressed, irq_ack, sd_rd_start, sd_byte_valid, sd_ready, uart_wr;
    logic [7:0] key_ascii, sd_byte;
    logic [3:0] irq_vector;
    logic [31:0] sd_addr, uart_data;

    logic [7:0] ref_mem [0:4095];  // byte model of the ram
    logic [7:0] sd_bytes [0:511];  // sector as fed in
    logic [15:0] lfsr;
    string test_name;
    logic [63:0] exp_rdata;
    logic [31:0] exp_sd_addr, exp_uart_data;
    logic [3:0] exp_irq;
    int exp_rd_start_cnt, exp_uart_cnt;
    int rd_start_cnt = 0;
    int uart_cnt = 0;
    int mismatch_count = 0;
    int other_count = 0;
    logic chk_reset, chk_rd, chk_outs; // arm the checkers for one edge

    tb_clock clkgen (.CLOCK_50(CLOCK_50), .KEY0(KEY0));

    soc_bus_top dut (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .bus_req(req), .bus_rdata(bus_rdata),
        .bus_done(bus_done), .key_pressed(key_pressed), .key_ascii(key_ascii),
        .irq_vector(irq_vector), .irq_ack(irq_ack), .sd_addr(sd_addr),
        .sd_rd_start(sd_rd_start), .sd_byte_valid(sd_byte_valid), .sd_byte(sd_byte),
        .sd_ready(sd_ready), .uart_wr(uart_wr), .uart_data(uart_data)
    );

    always @(posedge CLOCK_50) begin
        if (sd_rd_start) rd_start_cnt <= rd_start_cnt + 1; // pulse counters
        if (uart_wr) uart_cnt <= uart_cnt + 1;
    end

    function automatic void report_mismatch(input string name, input logic [63:0] expected,
                                            input logic [63:0] actual);
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        mismatch_count++;
    endfunction

    assert property (@(posedge CLOCK_50)
                     chk_reset |-> {irq_vector, bus_done, uart_wr, sd_rd_start} == 7'b0000100)
        else report_mismatch("reset state", 64'b100, {57'd0, irq_vector, bus_done, uart_wr,
                                                      sd_rd_start});
    assert property (@(posedge CLOCK_50) chk_rd |-> bus_rdata == exp_rdata)
        else report_mismatch(test_name, exp_rdata, bus_rdata);
    assert property (@(posedge CLOCK_50) chk_outs |-> irq_vector == exp_irq)
        else report_mismatch({test_name, " irq_vector"}, 64'(exp_irq), 64'(irq_vector));
    assert property (@(posedge CLOCK_50) chk_outs |-> sd_addr == exp_sd_addr)
        else report_mismatch({test_name, " sd_addr"}, 64'(exp_sd_addr), 64'(sd_addr));
    assert property (@(posedge CLOCK_50) chk_outs |-> rd_start_cnt == exp_rd_start_cnt)
        else report_mismatch({test_name, " sd_rd_start pulses"}, 64'(exp_rd_start_cnt),
                             64'(rd_start_cnt));
    assert property (@(posedge CLOCK_50) chk_outs |-> uart_cnt == exp_uart_cnt)
        else report_mismatch({test_name, " uart_wr pulses"}, 64'(exp_uart_cnt), 64'(uart_cnt));
    assert property (@(posedge CLOCK_50) uart_wr |-> uart_data == exp_uart_data)
        else report_mismatch("console data", 64'(exp_uart_data), 64'(uart_data));

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    function automatic int access_bytes(input soc_pkg::access_t kind);
        case (kind)
            soc_pkg::lb, soc_pkg::lbu: return 1;
            soc_pkg::lh, soc_pkg::lhu: return 2;
            soc_pkg::lw, soc_pkg::lwu: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic void store_ref(input logic [11:0] a, input soc_pkg::access_t kind,
                                      input logic [63:0] data);
        for (int i = 0; i < access_bytes(kind); i++) ref_mem[a + 12'(i)] = data[8*i +: 8];
    endfunction

    // little endian gather, sign fill only for lb lh lw
    function automatic logic [63:0] expect_load(input logic [11:0] a,
                                                input soc_pkg::access_t kind);
        logic [63:0] v;
        int n;
        v = '0;
        n = access_bytes(kind);
        for (int i = 0; i < n; i++) v[8*i +: 8] = ref_mem[a + 12'(i)];
        if ((kind == soc_pkg::lb || kind == soc_pkg::lh || kind == soc_pkg::lw) && v[8*n-1])
            for (int i = 8 * n; i < 64; i++) v[i] = 1'b1;
        return v;
    endfunction

    task automatic bus_write(input logic [63:0] addr, input soc_pkg::access_t kind,
                             input logic [63:0] data);
        @(negedge CLOCK_50);
        req.addr = addr;
        req.kind = kind;
        req.wdata = data;
        req.wr = 1'b1;
        @(negedge CLOCK_50);
        req.wr = 1'b0; // caller's next negedge leaves room for the upper word
    endtask

    task automatic check_read(input string name, input logic [63:0] addr,
                              input soc_pkg::access_t kind, input logic [63:0] expected);
        int waited;
        @(negedge CLOCK_50);
        test_name = name;
        exp_rdata = expected;
        req.addr = addr;
        req.kind = kind;
        req.rd = 1'b1;
        @(negedge CLOCK_50);
        req.rd = 1'b0;
        waited = 0;
        while (!bus_done && waited < 16) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (!bus_done) begin
            $display("%s: read at %h never finished, bus_done stayed low", name, addr);
            other_count++;
        end else begin
            chk_rd = 1'b1;
            @(negedge CLOCK_50);
            chk_rd = 1'b0;
        end
    endtask

    task automatic check_outputs(input string name);
        @(negedge CLOCK_50);
        test_name = name;
        chk_outs = 1'b1;
        @(negedge CLOCK_50);
        chk_outs = 1'b0;
    endtask

    task automatic press_key(input logic [7:0] code);
        @(negedge CLOCK_50);
        key_ascii = code;
        key_pressed = 1'b1;
        @(negedge CLOCK_50);
        key_pressed = 1'b0;
    endtask

    task automatic ram_test();
        logic [63:0] data;
        logic [11:0] a;
        soc_pkg::access_t kind;
        for (int w = 0; w < 512; w++) begin // whole ram known first
            data = take_bits(64);
            store_ref(12'(w * 8), soc_pkg::ld, data);
            bus_write(64'(w * 8), soc_pkg::ld, data);
        end
        for (int i = 0; i < 48; i++) begin
            kind = soc_pkg::access_t'(3'(take_bits(2))); // lb lh lw ld
            a = 12'(take_bits(12)) & ~12'(access_bytes(kind) - 1);
            data = take_bits(64);
            store_ref(a, kind, data);
            bus_write({52'd0, a}, kind, data);
        end
        for (int k = 0; k < 7; k++) begin
            kind = soc_pkg::access_t'(3'(k));
            for (int i = 0; i < 12; i++) begin
                a = 12'(take_bits(12)) & ~12'(access_bytes(kind) - 1);
                check_read($sformatf("ram load %s", kind.name()), {52'd0, a}, kind,
                           expect_load(a, kind));
            end
        end
    endtask

    task automatic key_test();
        logic [7:0] code;
        code = 8'(take_bits(7)) | 8'h01; // never zero
        press_key(code);
        exp_irq = 4'd1;
        check_outputs("key interrupt raised");
        check_read("key ascii", soc_pkg::key_addr, soc_pkg::ld, {56'd0, code});
        @(negedge CLOCK_50);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        exp_irq = 4'd0;
        check_outputs("key interrupt acknowledged");
        press_key(8'd0);
        check_outputs("key press with ascii zero");
    endtask

    task automatic sd_test();
        logic [63:0] data;
        data = take_bits(64);
        exp_sd_addr = data[31:0];
        bus_write(soc_pkg::sd_addr_reg, soc_pkg::ld, data);
        check_outputs("sd sector address");
        exp_rd_start_cnt++;
        bus_write(soc_pkg::sd_read_reg, soc_pkg::ld, 64'd1);
        check_outputs("sd read start");
        sd_ready = 1'b0; // card busy while the sector streams in
        check_read("sd ready while busy", soc_pkg::sd_ready_reg, soc_pkg::ld, 64'd0);
        check_read("sd available before fill", soc_pkg::sd_avail_reg, soc_pkg::ld, 64'd0);
        for (int i = 0; i < 512; i++) begin
            sd_bytes[i] = 8'(take_bits(8));
            @(negedge CLOCK_50);
            sd_byte = sd_bytes[i];
            sd_byte_valid = 1'b1; // one rising edge per byte
            @(negedge CLOCK_50);
            sd_byte_valid = 1'b0;
        end
        sd_ready = 1'b1;
        check_read("sd ready", soc_pkg::sd_ready_reg, soc_pkg::ld, 64'd1);
        check_read("sd available after fill", soc_pkg::sd_avail_reg, soc_pkg::ld, 64'd1);
        for (int i = 0; i < 512; i++)
            check_read($sformatf("sd buffer byte %0d", i), soc_pkg::sd_buf_base + 64'(i),
                       soc_pkg::lbu, {56'd0, sd_bytes[i]});
    endtask

    initial begin
        int waited;
        logic [63:0] data;
        req = '0;
        key_pressed = 1'b0;
        key_ascii = 8'd0;
        irq_ack = 1'b0;
        sd_byte_valid = 1'b0;
        sd_byte = 8'd0;
        sd_ready = 1'b1; // card idle
        {chk_reset, chk_rd, chk_outs} = '0;
        lfsr = 16'd61;
        exp_irq = 4'd0;
        exp_sd_addr = 32'd0;
        exp_uart_data = 32'd0;
        exp_rd_start_cnt = 0;
        exp_uart_cnt = 0;
        waited = 0;
        while (KEY0 !== 1'b1 && waited < 32) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (KEY0 !== 1'b1) begin
            $display("reset was never released");
            other_count++;
        end
        @(negedge CLOCK_50);
        chk_reset = 1'b1;
        @(negedge CLOCK_50);
        chk_reset = 1'b0;
        ram_test();
        key_test();
        sd_test();
        data = take_bits(64);
        test_name = "console write";
        exp_uart_data = data[31:0];
        exp_uart_cnt++;
        bus_write(soc_pkg::uart_addr, soc_pkg::ld, data);
        check_outputs("console write");
        // leave nonzero rdata before each unmapped read
        check_read("sd available before unmapped", soc_pkg::sd_avail_reg, soc_pkg::ld, 64'd1);
        check_read("unmapped read high", 64'h0000_0000_2000_0000 | (take_bits(12) & 64'hff8),
                   soc_pkg::ld, 64'd0);
        check_read("sd available again", soc_pkg::sd_avail_reg, soc_pkg::ld, 64'd1);
        check_read("unmapped read between registers", 64'h0000_0000_1000_0030, soc_pkg::ld,
                   64'd0);
        repeat (2) @(negedge CLOCK_50);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
hw/soc_pkg.sv
hw/bus_decode.sv
hw/ram_port.sv
hw/periph_regs.sv
hw/read_return.sv
hw/soc_bus_top.sv
testbench/tb_clock.sv
testbench/tb_soc_bus.sv

/* Makefile */
# verilator build and run of the soc bus fabric testbench
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= *** FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo '$(FAIL_MSG)' >> $(LOG); cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
